/* sources.f */
+incdir+.
predecPkg.sv
predecClassify.sv
predecSlotSelect.sv
predecRegs.sv
predecTop.sv
tbPredec.sv

/* Bender.yml */
package:
  name: predec

sources:
  - include_dirs:
      - .
    files:
      - predecPkg.sv
      - predecClassify.sv
      - predecSlotSelect.sv
      - predecRegs.sv
      - predecTop.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbPredec.sv

/* tbPredec.sv */
`timescale 1ns/100ps
`include "predecoder_cfg.svh"

module tbPredec;

  typedef struct packed {
    logic [255:0]     bundle;
    logic [14:0]      fillMask; // parcels that get random filler
    logic [3:0]       startOff;
    logic [8:0]       status;
    logic [5:0][31:0] instr;    // slots 0..3, then jump slots
    logic [5:0][15:0] meta;
  } testVec_t;

  localparam int NumVecs = 5;
  localparam int CyclesPerVec = 80; // 22 bus transfers of 3 clocks
  localparam int MaxCycles = NumVecs * CyclesPerVec + 100;

  logic              clk;
  logic              rstN;
  predecPkg::wbReq_t wbIn;
  predecPkg::wbRsp_t wbOut;
  testVec_t          vecs [NumVecs];
  integer            seed;
  logic [31:0]       rnd;
  int                errors;
  int                tests;
  int                failedTests;
  int                cycles;
  int                errsBefore;

  predecTop DUT (
    .clk   (clk),
    .rstN  (rstN),
    .wbIn  (wbIn),
    .wbOut (wbOut)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MaxCycles) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %08h expected %08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic waitAck(input logic [4:0] adr, output logic [31:0] dat);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!wbOut.ack && waited < 4) begin
      waited++;
      @(negedge clk);
    end
    dat = wbOut.dat;
    if (!wbOut.ack) begin
      $display("no ack from the DUT within 4 cycles for word %0d", adr);
      errors++;
    end
    @(posedge clk); // stb drops the cycle after ack
    wbIn.cyc <= 1'b0;
    wbIn.stb <= 1'b0;
    wbIn.we  <= 1'b0;
  endtask

  task automatic wbWrite(input logic [4:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    @(posedge clk);
    wbIn.cyc <= 1'b1;
    wbIn.stb <= 1'b1;
    wbIn.we  <= 1'b1;
    wbIn.adr <= adr;
    wbIn.dat <= dat;
    waitAck(adr, unused);
  endtask

  task automatic wbRead(input logic [4:0] adr, output logic [31:0] dat);
    @(posedge clk);
    wbIn.cyc <= 1'b1;
    wbIn.stb <= 1'b1;
    wbIn.we  <= 1'b0;
    wbIn.adr <= adr;
    waitAck(adr, dat);
  endtask

  task automatic readCheck(input string name, input logic [4:0] adr, input logic [31:0] exp);
    logic [31:0] got;
    wbRead(adr, got);
    check(name, got, exp);
  endtask

  task automatic checkSlots(input logic [5:0][31:0] instr, input logic [5:0][15:0] meta);
    for (int k = 0; k < `SLOTS; k++) begin
      readCheck($sformatf("slot%0d instr", k), 5'(`REG_SLOT0 + k), instr[k]);
      readCheck($sformatf("slot%0d meta", k), 5'(`REG_META0 + k), {16'h0, meta[k]});
    end
    for (int k = 0; k < `JSLOTS; k++) begin
      readCheck($sformatf("jslot%0d instr", k), 5'(`REG_JINSTR0 + k), instr[`SLOTS + k]);
      readCheck($sformatf("jslot%0d meta", k), 5'(`REG_JMETA0 + k), {16'h0, meta[`SLOTS + k]});
    end
  endtask

  task automatic endTest(input string name);
    tests++;
    if (errors == errsBefore) begin
      $display("%s: ok", name);
    end else begin
      failedTests++;
      $display("%s: %0d mismatches", name, errors - errsBefore);
    end
    errsBefore = errors;
  endtask

  task automatic runVec(input int n);
    testVec_t v;
    v = vecs[n];
    for (int w = 0; w < 8; w++) begin
      wbWrite(5'(`REG_BUNDLE0 + w), v.bundle[w*32 +: 32]);
    end
    wbWrite(`REG_CTRL, {28'h0, v.startOff});
    readCheck("status", `REG_STATUS, {23'h0, v.status});
    checkSlots(v.instr, v.meta);
    endTest($sformatf("vector %0d", n));
  endtask

  task automatic buildVectors();
    // short alu/jump singles, then a long tail start
    vecs[0].bundle   = {1'b0, 15'h400f, 80'h0, 80'h0, 80'h0030_00e5_0013_4431_1203};
    vecs[0].fillMask = 15'h7fe0;
    vecs[0].startOff = 4'h0;
    vecs[0].status   = 9'h15f;
    vecs[0].instr    = {32'h0, 32'h0013_4431, 32'h0030_00e5, 32'h00e5_0013,
                        32'h0013_4431, 32'h4431_1203};
    vecs[0].meta     = {16'h0, 16'h18a0, 16'h3e00, 16'h2c20, 16'h18a0, 16'h0020};
    // long load, store, mul, shift
    vecs[1].bundle   = {1'b0, 15'h4052, 80'h0, 80'h0000_7777_002b_0f0f_0026,
                        80'h9abc_5678_1253_beef_0042};
    vecs[1].fillMask = 15'h7e00;
    vecs[1].startOff = 4'h0;
    vecs[1].status   = 9'h10f;
    vecs[1].instr    = {32'h0, 32'h0, 32'h7777_002b, 32'h0f0f_0026,
                        32'h5678_1253, 32'hbeef_0042};
    vecs[1].meta     = {16'h0, 16'h0, 16'h7f10, 16'h5d08, 16'h2b02, 16'h0d04};
    // offset 4 skips the leading singles; sys, indirect jump, 182 miss, 181
    vecs[2].bundle   = {1'b0, 15'h42af, 80'h0000_0000_0000_4444_00b5,
                        80'h3333_20b6_2222_1fb6_1111, 80'h00ff_0000_0000_0000_0000};
    vecs[2].fillMask = 15'h700f;
    vecs[2].startOff = 4'h4;
    vecs[2].status   = 9'h13f;
    vecs[2].instr    = {32'h4444_00b5, 32'h2222_1fb6, 32'h4444_00b5, 32'h3333_20b6,
                        32'h2222_1fb6, 32'h1111_00ff};
    vecs[2].meta     = {16'haf80, 16'h65c0, 16'haf80, 16'h8d00, 16'h65c0, 16'h4501};
    // offset 15 masks every start
    vecs[3].bundle   = {1'b0, 15'h1234, 240'h0};
    vecs[3].fillMask = 15'h7fff;
    vecs[3].startOff = 4'hf;
    vecs[3].status   = 9'h140;
    vecs[3].instr    = '0;
    vecs[3].meta     = '0;
    // seven starts, three jumps
    vecs[4].bundle   = {1'b0, 15'h403f, 80'h0, 80'h0034, 80'h0033_0014_0032_0001_0031};
    vecs[4].fillMask = 15'h7f80;
    vecs[4].startOff = 4'h0;
    vecs[4].status   = 9'h1ff;
    vecs[4].instr    = {32'h0014_0032, 32'h0001_0031, 32'h0033_0014, 32'h0014_0032,
                        32'h0032_0001, 32'h0001_0031};
    vecs[4].meta     = {16'h20a0, 16'h00a0, 16'h3800, 16'h20a0, 16'h1020, 16'h00a0};
    for (int n = 0; n < NumVecs; n++) begin
      for (int k = 0; k < `PARCELS; k++) begin
        if (vecs[n].fillMask[k]) begin
          rnd = $random(seed);
          vecs[n].bundle[k*16 +: 16] = rnd[15:0];
        end
      end
      rnd = $random(seed);
      vecs[n].bundle[255] = rnd[0]; // reserved bit
    end
  endtask

  initial begin
    rstN        = 1'b0;
    wbIn        = '0;
    seed        = 32'hec0;
    errors      = 0;
    tests       = 0;
    failedTests = 0;
    cycles      = 0;
    errsBefore  = 0;
    buildVectors();
    repeat (2) @(posedge clk);
    rstN <= 1'b1;

    readCheck("status", `REG_STATUS, 32'h0);
    checkSlots('0, '0);
    endTest("after reset");

    for (int n = 0; n < NumVecs; n++) begin
      runVec(n);
    end

    // rewrite the same top word, result stays but ready drops
    wbWrite(5'(`REG_BUNDLE0 + 7), vecs[NumVecs-1].bundle[255:224]);
    readCheck("status", `REG_STATUS, {23'h0, 1'b0, vecs[NumVecs-1].status[7:0]});
    wbWrite(`REG_CTRL, {28'h0, vecs[NumVecs-1].startOff});
    readCheck("status", `REG_STATUS, {23'h0, vecs[NumVecs-1].status});
    endTest("stale bundle");

    $display("%0d tests, %0d failed, %0d mismatches", tests, failedTests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* predecTop.sv */
`timescale 1ns/100ps

module predecTop (
  input  logic              clk,
  input  logic              rstN,
  input  predecPkg::wbReq_t wbIn,
  output predecPkg::wbRsp_t wbOut
);

  logic [255:0]             bundle;
  logic [3:0]               startOff;
  logic                     decodeGo;
  logic                     resultValid;
  predecPkg::predecResult_t result;

  predecRegs uRegs (
    .clk         (clk),
    .rstN        (rstN),
    .wbIn        (wbIn),
    .wbOut       (wbOut),
    .bundle      (bundle),
    .startOff    (startOff),
    .decodeGo    (decodeGo),
    .result      (result),
    .resultValid (resultValid)
  );

  predecSlotSelect uSlotSelect (
    .clk         (clk),
    .rstN        (rstN),
    .bundle      (bundle),
    .startOff    (startOff),
    .decodeGo    (decodeGo),
    .result      (result),
    .resultValid (resultValid)
  );

endmodule

/* predecRegs.sv */
`timescale 1ns/100ps
`include "predecoder_cfg.svh"

module predecRegs (
  input  logic                     clk,
  input  logic                     rstN,
  input  predecPkg::wbReq_t        wbIn,
  output predecPkg::wbRsp_t        wbOut,
  output logic [255:0]             bundle,
  output logic [3:0]               startOff,
  output logic                     decodeGo,
  input  predecPkg::predecResult_t result,
  input  logic                     resultValid
);

  logic                     ack;
  logic                     req;
  logic                     isBundle;
  logic                     isCtrl;
  logic                     bundleStale;
  logic [`WB_ADDR_BITS-1:0] bIdx;
  logic [`WB_ADDR_BITS-1:0] idx;
  logic [31:0]              rdNext;
  logic [31:0]              rdData;

  function automatic logic [31:0] metaWord(input predecPkg::slot_t s);
    return {16'b0, s.off, s.magic, s.cls};
  endfunction

  assign req      = wbIn.cyc & wbIn.stb & ~ack; // one ack per request
  assign isBundle = wbIn.adr >= `REG_BUNDLE0 && wbIn.adr < `REG_CTRL;
  assign isCtrl   = wbIn.adr == `REG_CTRL;
  assign bIdx     = wbIn.adr - `WB_ADDR_BITS'(`REG_BUNDLE0);

  assign wbOut.ack = ack;
  assign wbOut.dat = rdData;

  always_comb begin
    idx    = '0;
    rdNext = '0;
    if (isBundle) begin
      rdNext = bundle[bIdx[2:0]*32 +: 32];
    end else if (isCtrl) begin
      rdNext = {28'b0, startOff};
    end else if (wbIn.adr == `REG_STATUS) begin
      rdNext = {23'b0, resultValid & ~bundleStale, result.jumpError, result.overflow,
                result.jumpEn, result.instrEn};
    end else if (wbIn.adr >= `REG_SLOT0 && wbIn.adr < `REG_META0) begin
      idx    = wbIn.adr - `WB_ADDR_BITS'(`REG_SLOT0);
      rdNext = result.slots[idx[1:0]].instr;
    end else if (wbIn.adr >= `REG_META0 && wbIn.adr < `REG_JINSTR0) begin
      idx    = wbIn.adr - `WB_ADDR_BITS'(`REG_META0);
      rdNext = metaWord(result.slots[idx[1:0]]);
    end else if (wbIn.adr >= `REG_JINSTR0 && wbIn.adr < `REG_JMETA0) begin
      idx    = wbIn.adr - `WB_ADDR_BITS'(`REG_JINSTR0);
      rdNext = result.jslots[idx[0]].instr;
    end else if (wbIn.adr >= `REG_JMETA0 && wbIn.adr < `REG_JMETA0 + `JSLOTS) begin
      idx    = wbIn.adr - `WB_ADDR_BITS'(`REG_JMETA0);
      rdNext = metaWord(result.jslots[idx[0]]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ack         <= 1'b0;
      decodeGo    <= 1'b0;
      startOff    <= '0;
      bundleStale <= 1'b0;
    end else begin
      ack      <= req;
      decodeGo <= req & wbIn.we & isCtrl; // high with the ctrl ack
      if (req && wbIn.we && isCtrl) begin
        startOff <= wbIn.dat[3:0];
      end
      if (decodeGo) begin
        bundleStale <= 1'b0;
      end else if (req && wbIn.we && isBundle) begin
        bundleStale <= 1'b1; // result no longer matches bundle
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req && wbIn.we && isBundle) begin
      bundle[bIdx[2:0]*32 +: 32] <= wbIn.dat;
    end
    if (req) begin
      rdData <= rdNext;
    end
  end

endmodule

/* predecSlotSelect.sv */
`timescale 1ns/100ps
`include "predecoder_cfg.svh"

module predecSlotSelect (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic [255:0]             bundle,
  input  logic [3:0]               startOff,
  input  logic                     decodeGo,
  output predecPkg::predecResult_t result,
  output logic                     resultValid
);

  localparam int BodyBits = `PARCELS * `PARCEL_BITS;

  logic [(`PARCELS+1)*`PARCEL_BITS-1:0]  padded;
  logic [`PARCELS+2:0]                   endMark;
  logic [`PARCELS-1:0]                   startMark;
  logic [`PARCELS-1:0]                   live;
  logic [`PARCELS-1:0][3:0]              magics;
  predecPkg::firstWord_t [`PARCELS-1:0]  words;
  predecPkg::instrClass_t [`PARCELS-1:0] classes;
  predecPkg::slot_t [`PARCELS-1:0]       slotAt;
  predecPkg::predecResult_t              nxt;
  logic [4:0]                            cnt;
  logic [4:0]                            jcnt;

  // parcels past the bundle are zero and end-marked
  assign padded  = {{`PARCEL_BITS{1'b0}}, bundle[BodyBits-1:0]};
  assign endMark = {3'b111, bundle[BodyBits +: `PARCELS]};

  for (genvar k = 0; k < `PARCELS; k++) begin : genParcel
    if (k == 0) begin : genFirst
      assign startMark[k] = 1'b1;
    end else begin : genRest
      assign startMark[k] = endMark[k-1];
    end
    assign live[k]   = startMark[k] && (k >= startOff);
    assign magics[k] = ~endMark[k +: 4];
    assign words[k]  = padded[k*`PARCEL_BITS +: 2*`PARCEL_BITS];

    predecClassify uClassify (
      .word  (words[k]),
      .magic (magics[k]),
      .cls   (classes[k])
    );

    assign slotAt[k] = {words[k], classes[k], magics[k], 4'(k)};
  end

  // k-th live start goes to slot k
  always_comb begin
    nxt  = '0;
    cnt  = '0;
    jcnt = '0;
    for (int k = 0; k < `PARCELS; k++) begin
      if (live[k]) begin
        if (cnt < `SLOTS) begin
          nxt.slots[cnt[1:0]]   = slotAt[k];
          nxt.instrEn[cnt[1:0]] = 1'b1;
        end
        cnt = cnt + 5'd1;
        if (classes[k].jump) begin
          if (jcnt < `JSLOTS) begin
            nxt.jslots[jcnt[0]] = slotAt[k];
            nxt.jumpEn[jcnt[0]] = 1'b1;
          end
          jcnt = jcnt + 5'd1;
        end
      end
    end
    nxt.overflow  = (cnt > `SLOTS) || (startOff == 4'd15);
    nxt.jumpError = jcnt > `JSLOTS;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      result      <= '0;
      resultValid <= 1'b0;
    end else if (decodeGo) begin
      result      <= nxt;
      resultValid <= 1'b1;
    end
  end

endmodule

/* predecClassify.sv */
`timescale 1ns/100ps

module predecClassify (
  input  predecPkg::firstWord_t  word,
  input  logic [3:0]             magic,
  output predecPkg::instrClass_t cls
);

  logic [7:0] mainOp;
  logic [5:0] subOp;
  logic [2:0] jmpSel;

  assign mainOp = word.lng.mainOp;
  assign subOp  = word.shrt.subOp;
  assign jmpSel = word.lng.upper[7:5]; // word bits 15..13

  always_comb begin
    cls = '0;
    if (magic[0]) begin
      // long form
      if (mainOp <= 8'd39) begin
        cls.alu = ~mainOp[2];
        cls.mul = mainOp[2];
      end
      if (mainOp >= 8'd40 && mainOp <= 8'd45) begin
        cls.shift = 1'b1;
      end
      if (mainOp[7:5] == 3'b010) begin // 64..95
        cls.load  = ~mainOp[0];
        cls.store = mainOp[0];
      end
      if (mainOp[7:4] == 4'b1010) begin // cond jumps
        cls.jump = 1'b1;
        cls.alu  = 1'b1;
      end
      if (mainOp == 8'd181) begin
        cls.jump = 1'b1;
      end
      if (mainOp == 8'd182 && jmpSel == 3'd0) begin
        cls.jump  = 1'b1;
        cls.indir = 1'b1;
      end
      if (mainOp == 8'hff) begin
        cls.sys = 1'b1;
      end
    end else begin
      // short form
      if (subOp <= 6'd19) begin
        cls.alu = 1'b1;
      end
      if (subOp[5:2] == 4'b1100) begin // 48..51
        cls.jump = 1'b1;
        cls.alu  = 1'b1;
      end
    end
  end

endmodule

/* predecPkg.sv */
`include "predecoder_cfg.svh"

package predecPkg;

  typedef struct packed {
    logic jump;
    logic indir;
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic sys;
  } instrClass_t;

  // multi-parcel instructions carry an 8 bit opcode
  typedef struct packed {
    logic [23:0] upper;
    logic [7:0]  mainOp;
  } longWord_t;

  // single parcel form, 6 bit sub opcode
  typedef struct packed {
    logic [23:0] upper;
    logic [1:0]  spare;
    logic [5:0]  subOp;
  } shortWord_t;

  typedef union packed {
    longWord_t  lng;
    shortWord_t shrt;
  } firstWord_t;

  typedef struct packed {
    firstWord_t  instr;
    instrClass_t cls;
    logic [3:0]  magic;
    logic [3:0]  off;   // start parcel
  } slot_t;

  typedef struct packed {
    slot_t [`SLOTS-1:0]  slots;
    slot_t [`JSLOTS-1:0] jslots;
    logic [`SLOTS-1:0]   instrEn;
    logic [`JSLOTS-1:0]  jumpEn;
    logic                overflow;
    logic                jumpError;
  } predecResult_t;

  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`WB_ADDR_BITS-1:0] adr;
    logic [31:0]              dat;
  } wbReq_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wbRsp_t;

endpackage

/* predecoder_cfg.svh */
`ifndef PREDECODER_CFG_SVH
`define PREDECODER_CFG_SVH

// bundle geometry
`define PARCEL_BITS 16
`define PARCELS 15

// slot counts
`define SLOTS 4
`define JSLOTS 2

// register word address width
`define WB_ADDR_BITS 5

// word addresses
`define REG_BUNDLE0 0
`define REG_CTRL 8
`define REG_STATUS 9
`define REG_SLOT0 10
`define REG_META0 14
`define REG_JINSTR0 18
`define REG_JMETA0 20

`endif
